// ==== verilog/mem_subsys_pkg.sv ====
`default_nettype none

package mem_subsys_pkg;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  localparam logic [31:0] RAM_BASE      = 32'h4000_0000;
  localparam int          RAM_WORDS     = 1024;
  localparam int          RAM_AW        = $clog2(RAM_WORDS);
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  // Emulated RAM latency, registered request to acknowledge
  localparam int RAM_DELAY = 16;

  // Tag and page values compared against the decoded address
  localparam logic [31-RAM_AW-2:0] RAM_TAG    = RAM_BASE[31:RAM_AW+2];
  localparam logic [27:0]          TIMER_PAGE = TIMER_LO_ADDR[31:4];

  // Region codes of a registered request
  localparam logic [1:0] REGION_NONE = 2'd0;
  localparam logic [1:0] REGION_RAM  = 2'd1;
  localparam logic [1:0] REGION_TLO  = 2'd2;
  localparam logic [1:0] REGION_THI  = 2'd3;

  ////////////////////////////////////////////////////////////
  // Serial loader
  ////////////////////////////////////////////////////////////

  localparam int                CLKS_PER_BIT = 16;
  localparam int                BIT_CW       = $clog2(CLKS_PER_BIT);
  localparam logic [BIT_CW-1:0] BIT_MID      = BIT_CW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [BIT_CW-1:0] BIT_LAST     = BIT_CW'(CLKS_PER_BIT - 1);
  localparam logic [7:0]        PROG_START   = 8'h50;

  // Receiver states
  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;
  localparam logic [1:0] RX_STOP  = 2'd3;

  // Loader states
  localparam logic [1:0] LD_IDLE = 2'd0;
  localparam logic [1:0] LD_LEN  = 2'd1;
  localparam logic [1:0] LD_DATA = 2'd2;

  // One bus address, seen as a RAM word or as an IO register
  typedef union packed {
    struct packed {
      logic [31-RAM_AW-2:0] tag;
      logic [RAM_AW-1:0]    word;
      logic [1:0]           byte_off;
    } ram;
    struct packed {
      logic [27:0] page;
      logic [3:0]  reg_off;
    } io;
  } mem_addr_u;

endpackage

`default_nettype wire

// ==== verilog/bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  logic                              clk_i,
  input  logic                              rst_n,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [3:0]                        wb_sel_i,
  input  logic [31:0]                       wb_adr_i,
  input  logic [31:0]                       wb_dat_i,
  input  logic                              sys_hold,
  input  logic                              ram_done,
  input  logic [31:0]                       ram_rdata,
  input  logic [31:0]                       tmr_rdata,
  output logic [31:0]                       wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              ram_start,
  output logic [3:0]                        ram_we_strb,
  output logic [mem_subsys_pkg::RAM_AW-1:0] ram_addr,
  output logic [31:0]                       ram_wdata,
  output logic                              tmr_rd,
  output logic                              tmr_hi
);

  mem_subsys_pkg::mem_addr_u adr_in;
  mem_subsys_pkg::mem_addr_u adr_q;
  logic [1:0]                region_in;
  logic [1:0]                region_q;
  logic                      req_busy;
  logic                      accept;
  logic                      we_q;
  logic [3:0]                sel_q;
  logic [31:0]               dat_q;

  assign adr_in = wb_adr_i;

  // Region classification
  always_comb begin
    if (adr_in.ram.tag == mem_subsys_pkg::RAM_TAG) begin
      region_in = mem_subsys_pkg::REGION_RAM;
    end else if (adr_in.io.page == mem_subsys_pkg::TIMER_PAGE &&
                 adr_in.io.reg_off == mem_subsys_pkg::TIMER_LO_ADDR[3:0]) begin
      region_in = mem_subsys_pkg::REGION_TLO;
    end else if (adr_in.io.page == mem_subsys_pkg::TIMER_PAGE &&
                 adr_in.io.reg_off == mem_subsys_pkg::TIMER_HI_ADDR[3:0]) begin
      region_in = mem_subsys_pkg::REGION_THI;
    end else begin
      region_in = mem_subsys_pkg::REGION_NONE;
    end
  end

  // New request only when idle and the loader is not holding the system
  assign accept    = wb_cyc_i & wb_stb_i & ~req_busy & ~sys_hold;
  assign ram_start = accept & (region_in == mem_subsys_pkg::REGION_RAM);

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      req_busy <= 1'b0;
      wb_ack_o <= 1'b0;
      tmr_rd   <= 1'b0;
    end else begin
      // RAM waits for the latency stage, everything else answers next cycle
      wb_ack_o <= req_busy & ~wb_ack_o &
                  ((region_q == mem_subsys_pkg::REGION_RAM) ? ram_done : 1'b1);
      tmr_rd   <= accept & ~wb_we_i &
                  ((region_in == mem_subsys_pkg::REGION_TLO) ||
                   (region_in == mem_subsys_pkg::REGION_THI));
      if (accept) begin
        req_busy <= 1'b1;
      end else if (wb_ack_o) begin
        req_busy <= 1'b0;
      end
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q    <= adr_in;
      region_q <= region_in;
      we_q     <= wb_we_i;
      sel_q    <= wb_sel_i;
      dat_q    <= wb_dat_i;
    end
  end

  assign ram_addr    = adr_q.ram.word;
  assign ram_wdata   = dat_q;
  assign ram_we_strb = (req_busy && we_q && region_q == mem_subsys_pkg::REGION_RAM) ?
                       sel_q : 4'b0000;
  assign tmr_hi      = (adr_q.io.reg_off == mem_subsys_pkg::TIMER_HI_ADDR[3:0]);

  // Read data by registered region, unmapped reads give zero
  always_comb begin
    case (region_q)
      mem_subsys_pkg::REGION_RAM: wb_dat_o = ram_rdata;
      mem_subsys_pkg::REGION_TLO: wb_dat_o = tmr_rdata;
      mem_subsys_pkg::REGION_THI: wb_dat_o = tmr_rdata;
      default:                    wb_dat_o = 32'h0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/ram_latency.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_latency (
  input  logic clk_i,
  input  logic rst_n,
  input  logic ram_start,
  output logic ram_done
);

  logic [mem_subsys_pkg::RAM_DELAY-1:0] delay_q;

  ////////////////////////////////////////////////////////////
  // Latency shift chain
  ////////////////////////////////////////////////////////////

  // A single token walks through the chain, one stage per cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      delay_q <= '0;
    end else begin
      delay_q <= {delay_q[mem_subsys_pkg::RAM_DELAY-2:0], ram_start};
    end
  end

  // Token leaving the last stage ends the wait
  assign ram_done = delay_q[mem_subsys_pkg::RAM_DELAY-1];

endmodule

`default_nettype wire

// ==== verilog/main_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_ram (
  input  logic                              clk_i,
  input  logic [3:0]                        ram_we_strb,
  input  logic [mem_subsys_pkg::RAM_AW-1:0] ram_addr,
  input  logic [31:0]                       ram_wdata,
  input  logic                              ld_we,
  input  logic [mem_subsys_pkg::RAM_AW-1:0] ld_addr,
  input  logic [31:0]                       ld_data,
  output logic [31:0]                       ram_rdata
);

  logic [31:0] mem [mem_subsys_pkg::RAM_WORDS];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  // Loader owns the port during a program load
  always_ff @(posedge clk_i) begin
    if (ld_we) begin
      mem[ld_addr] <= ld_data;
    end else begin
      for (int lane = 0; lane < 4; lane++) begin
        if (ram_we_strb[lane]) begin
          mem[ram_addr][8*lane +: 8] <= ram_wdata[8*lane +: 8];
        end
      end
    end
  end

  // Registered read
  always_ff @(posedge clk_i) begin
    ram_rdata <= mem[ram_addr];
  end

endmodule

`default_nettype wire

// ==== verilog/timer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_regs (
  input  logic        clk_i,
  input  logic        rst_n,
  input  logic        sys_hold,
  input  logic        tmr_rd,
  input  logic        tmr_hi,
  output logic [31:0] tmr_rdata
);

  logic [63:0] count_q;
  logic [31:0] hi_snap_q;

  // Free-running cycle counter, held at zero during a load
  always_ff @(posedge clk_i) begin
    if (!rst_n || sys_hold) begin
      count_q <= 64'h0;
    end else begin
      count_q <= count_q + 64'h1;
    end
  end

  // Low read snapshots the high half so the following high read matches
  always_ff @(posedge clk_i) begin
    if (tmr_rd) begin
      if (tmr_hi) begin
        tmr_rdata <= hi_snap_q;
      end else begin
        tmr_rdata <= count_q[31:0];
        hi_snap_q <= count_q[63:32];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/prog_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module prog_loader (
  input  logic                              clk_i,
  input  logic                              rst_n,
  input  logic                              prog_rx_i,
  output logic                              ld_we,
  output logic [mem_subsys_pkg::RAM_AW-1:0] ld_addr,
  output logic [31:0]                       ld_data,
  output logic                              sys_hold,
  output logic                              prog_mode_o
);

  logic                              rx_meta;
  logic                              rx_sync;
  logic [1:0]                        rx_state;
  logic [mem_subsys_pkg::BIT_CW-1:0] clk_cnt;
  logic [2:0]                        bit_idx;
  logic [7:0]                        rx_byte;
  logic                              byte_valid;
  logic [1:0]                        ld_state;
  logic                              len_hi;
  logic [15:0]                       remain;
  logic [1:0]                        byte_sel;
  logic [mem_subsys_pkg::RAM_AW-1:0] word_idx;
  logic                              ld_last;
  logic [23:0]                       word_buf;

  ////////////////////////////////////////////////////////////
  // 8N1 receiver, mid-bit sampling
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      rx_state   <= mem_subsys_pkg::RX_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= 3'd0;
      rx_byte    <= 8'h00;
      byte_valid <= 1'b0;
    end else begin
      rx_meta    <= prog_rx_i;
      rx_sync    <= rx_meta;
      byte_valid <= 1'b0;
      clk_cnt    <= clk_cnt + 1'b1;
      case (rx_state)
        mem_subsys_pkg::RX_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) begin
            rx_state <= mem_subsys_pkg::RX_START;
          end
        end
        mem_subsys_pkg::RX_START: begin
          // Recheck the start bit at its middle
          if (clk_cnt == mem_subsys_pkg::BIT_MID) begin
            clk_cnt  <= '0;
            bit_idx  <= 3'd0;
            rx_state <= rx_sync ? mem_subsys_pkg::RX_IDLE : mem_subsys_pkg::RX_DATA;
          end
        end
        mem_subsys_pkg::RX_DATA: begin
          if (clk_cnt == mem_subsys_pkg::BIT_LAST) begin
            clk_cnt <= '0;
            rx_byte <= {rx_sync, rx_byte[7:1]};
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              rx_state <= mem_subsys_pkg::RX_STOP;
            end
          end
        end
        default: begin
          // Framing error drops the byte
          if (clk_cnt == mem_subsys_pkg::BIT_LAST) begin
            byte_valid <= rx_sync;
            rx_state   <= mem_subsys_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Program-mode FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ld_state <= mem_subsys_pkg::LD_IDLE;
      sys_hold <= 1'b0;
      ld_we    <= 1'b0;
      ld_last  <= 1'b0;
      len_hi   <= 1'b0;
      remain   <= 16'h0;
      byte_sel <= 2'd0;
      word_idx <= '0;
    end else begin
      ld_we   <= 1'b0;
      ld_last <= 1'b0;
      // Release one cycle after the final word lands
      if (ld_we && ld_last) begin
        sys_hold <= 1'b0;
      end
      case (ld_state)
        mem_subsys_pkg::LD_IDLE: begin
          if (byte_valid && rx_byte == mem_subsys_pkg::PROG_START) begin
            sys_hold <= 1'b1;
            len_hi   <= 1'b0;
            ld_state <= mem_subsys_pkg::LD_LEN;
          end
        end
        mem_subsys_pkg::LD_LEN: begin
          if (byte_valid) begin
            if (!len_hi) begin
              remain[7:0] <= rx_byte;
              len_hi      <= 1'b1;
            end else begin
              remain[15:8] <= rx_byte;
              byte_sel     <= 2'd0;
              word_idx     <= '0;
              // Empty load ends right away
              if ({rx_byte, remain[7:0]} == 16'h0) begin
                sys_hold <= 1'b0;
                ld_state <= mem_subsys_pkg::LD_IDLE;
              end else begin
                ld_state <= mem_subsys_pkg::LD_DATA;
              end
            end
          end
        end
        mem_subsys_pkg::LD_DATA: begin
          if (byte_valid) begin
            byte_sel <= byte_sel + 2'd1;
            if (byte_sel == 2'd3) begin
              ld_we    <= 1'b1;
              word_idx <= word_idx + 1'b1;
              remain   <= remain - 16'd1;
              if (remain == 16'd1) begin
                ld_last  <= 1'b1;
                ld_state <= mem_subsys_pkg::LD_IDLE;
              end
            end
          end
        end
        default: ld_state <= mem_subsys_pkg::LD_IDLE;
      endcase
    end
  end

  // Word assembly, little-endian
  always_ff @(posedge clk_i) begin
    if (ld_state == mem_subsys_pkg::LD_DATA && byte_valid) begin
      word_buf <= {rx_byte, word_buf[23:8]};
      if (byte_sel == 2'd3) begin
        ld_data <= {rx_byte, word_buf};
        ld_addr <= word_idx;
      end
    end
  end

  assign prog_mode_o = sys_hold;

endmodule

`default_nettype wire

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  logic        clk_i,
  input  logic        rst_n,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [3:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic        prog_rx_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        prog_mode_o,
  output logic        sys_rst_n_o
);

  logic                              sys_hold;
  logic                              ram_start;
  logic                              ram_done;
  logic [3:0]                        ram_we_strb;
  logic [mem_subsys_pkg::RAM_AW-1:0] ram_addr;
  logic [31:0]                       ram_wdata;
  logic [31:0]                       ram_rdata;
  logic                              tmr_rd;
  logic                              tmr_hi;
  logic [31:0]                       tmr_rdata;
  logic                              ld_we;
  logic [mem_subsys_pkg::RAM_AW-1:0] ld_addr;
  logic [31:0]                       ld_data;

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  bus_decode u_bus_decode (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .sys_hold    (sys_hold),
    .ram_done    (ram_done),
    .ram_rdata   (ram_rdata),
    .tmr_rdata   (tmr_rdata),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .ram_start   (ram_start),
    .ram_we_strb (ram_we_strb),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .tmr_rd      (tmr_rd),
    .tmr_hi      (tmr_hi)
  );

  ram_latency u_ram_latency (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .ram_start (ram_start),
    .ram_done  (ram_done)
  );

  main_ram u_main_ram (
    .clk_i       (clk_i),
    .ram_we_strb (ram_we_strb),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ld_we       (ld_we),
    .ld_addr     (ld_addr),
    .ld_data     (ld_data),
    .ram_rdata   (ram_rdata)
  );

  timer_regs u_timer_regs (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .sys_hold  (sys_hold),
    .tmr_rd    (tmr_rd),
    .tmr_hi    (tmr_hi),
    .tmr_rdata (tmr_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Loader side
  ////////////////////////////////////////////////////////////

  prog_loader u_prog_loader (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .prog_rx_i   (prog_rx_i),
    .ld_we       (ld_we),
    .ld_addr     (ld_addr),
    .ld_data     (ld_data),
    .sys_hold    (sys_hold),
    .prog_mode_o (prog_mode_o)
  );

  // Processor reset follows the load hold
  assign sys_rst_n_o = ~sys_hold;

endmodule

`default_nettype wire

// ==== dv/mem_subsys_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_chk (
  input logic clk_i,
  input logic rst_n,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic ram_start,
  input logic sys_hold
);

  ////////////////////////////////////////////////////////////
  // Wishbone handshake
  ////////////////////////////////////////////////////////////

  // Acknowledge only inside a strobe
  ack_within_stb: assert property (
    @(posedge clk_i) disable iff (!rst_n) wb_ack_o |-> wb_stb_i
  ) else $error("wb_ack_o raised without wb_stb_i");

  // Single-cycle acknowledge
  ack_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n) wb_ack_o |=> !wb_ack_o
  ) else $error("wb_ack_o high for two cycles in a row");

  ////////////////////////////////////////////////////////////
  // Loader interaction
  ////////////////////////////////////////////////////////////

  // Bus is blocked while the loader holds the system
  no_ram_start_in_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n) ram_start |-> !sys_hold
  ) else $error("ram_start issued while sys_hold is high");

endmodule

`default_nettype wire

// ==== dv/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

  localparam int CLK_HALF    = 10;
  localparam int RAM_OPS     = 40;
  localparam int UNMAP_OPS   = 8;
  localparam int LOAD_WORDS  = 6;
  localparam int NOISE_BYTES = 4;
  localparam int RAM_LAT     = mem_subsys_pkg::RAM_DELAY + 1;
  localparam int IO_LAT      = 2;
  // Access cycles with the drop cycle and the idle gap
  localparam int RAM_ACC     = RAM_LAT + 2;
  localparam int IO_ACC      = IO_LAT + 2;
  localparam int BYTE_CYC    = 10 * mem_subsys_pkg::CLKS_PER_BIT;
  localparam int LOAD_BYTES  = 3 + 4 * LOAD_WORDS;
  localparam int EXPECT_CYC  = 5 + 2 * RAM_OPS * RAM_ACC + 6 * IO_ACC + UNMAP_OPS * IO_ACC +
                               (LOAD_BYTES + NOISE_BYTES) * BYTE_CYC +
                               (LOAD_WORDS + 1) * RAM_ACC;
  localparam int CYCLE_LIMIT = 2 * EXPECT_CYC;

  logic        clk_i;
  logic        rst_n;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic        prog_rx_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        prog_mode_o;
  logic        sys_rst_n_o;

  logic [31:0] rng_state;
  logic [31:0] model_mem [mem_subsys_pkg::RAM_WORDS];
  logic [3:0]  model_known [mem_subsys_pkg::RAM_WORDS];
  logic [63:0] run_cycles;
  int          cycle_count;
  int          err_count;
  int          test_base;
  int          tests_run;
  int          tests_failed;
  int          ram_lats [$];

  mem_subsys_top UUT (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .prog_rx_i   (prog_rx_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .prog_mode_o (prog_mode_o),
    .sys_rst_n_o (sys_rst_n_o)
  );

  bind bus_decode mem_subsys_chk u_chk (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_o  (wb_ack_o),
    .ram_start (ram_start),
    .sys_hold  (sys_hold)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // Mirror of the free-running timer that clears on reset and during a load
  always @(posedge clk_i) begin
    if (!rst_n || !sys_rst_n_o) begin
      run_cycles <= 64'h0;
    end else begin
      run_cycles <= run_cycles + 64'h1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] lanes);
    logic [31:0] mask;
    for (int l = 0; l < 4; l++) begin
      mask[8*l +: 8] = {8{lanes[l]}};
    end
    return mask;
  endfunction

  function automatic logic is_mapped(input logic [31:0] adr);
    logic [31:0] ram_end;
    ram_end = mem_subsys_pkg::RAM_BASE + 32'(mem_subsys_pkg::RAM_WORDS * 4);
    return (adr >= mem_subsys_pkg::RAM_BASE && adr < ram_end) ||
           (adr[31:4] == mem_subsys_pkg::TIMER_LO_ADDR[31:4]);
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Error: %s expected %0h actual %0h", name, exp, act);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    err_count++;
  endtask

  task automatic begin_test();
    test_base = err_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == test_base) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAILED with %0d errors", name, err_count - test_base);
    end
  endtask

  // Byte-merge a bus write into the RAM model
  task automatic model_write(input int idx, input logic [3:0] sel, input logic [31:0] dat);
    for (int l = 0; l < 4; l++) begin
      if (sel[l]) begin
        model_mem[idx][8*l +: 8] = dat[8*l +: 8];
        model_known[idx][l]      = 1'b1;
      end
    end
  endtask

  // One Wishbone classic cycle with latency counted in clocks from the stb cycle
  task automatic wb_access(
    input  logic        we,
    input  logic [3:0]  sel,
    input  logic [31:0] adr,
    input  logic [31:0] dat,
    output logic [31:0] rdata,
    output int          lat
  );
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = adr;
    wb_dat_i = dat;
    lat      = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!wb_ack_o);
    rdata    = wb_dat_o;
    // Strobe stays up through the acknowledge cycle
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic send_bit(input logic level);
    prog_rx_i = level;
    repeat (mem_subsys_pkg::CLKS_PER_BIT) @(negedge clk_i);
  endtask

  // 8N1 frame with LSB first
  task automatic send_byte(input logic [7:0] value);
    send_bit(1'b0);
    for (int b = 0; b < 8; b++) begin
      send_bit(value[b]);
    end
    send_bit(1'b1);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] mask;
    logic [31:0] held_rdata;
    logic [31:0] load_data [LOAD_WORDS];
    logic [63:0] pair;
    logic [63:0] first_pair;
    logic [63:0] tmr_exp;
    logic [7:0]  noise;
    logic [3:0]  sel;
    int          idx;
    int          lat;
    int          held_lat;
    int          ram_idx [RAM_OPS];

    clk_i        = 1'b0;
    rst_n        = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_sel_i     = 4'h0;
    wb_adr_i     = 32'h0;
    wb_dat_i     = 32'h0;
    prog_rx_i    = 1'b1;
    rng_state    = 32'he89a;
    cycle_count  = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < mem_subsys_pkg::RAM_WORDS; i++) begin
      model_known[i] = 4'h0;
    end

    repeat (3) @(negedge clk_i);
    rst_n = 1'b1;

    // Reset state
    begin_test();
    @(negedge clk_i);
    if (wb_ack_o !== 1'b0) report_mismatch("reset_ack", 0, wb_ack_o);
    if (prog_mode_o !== 1'b0) report_mismatch("reset_mode", 0, prog_mode_o);
    if (sys_rst_n_o !== 1'b1) report_mismatch("reset_sys_rst_n", 1, sys_rst_n_o);
    end_test("reset_state");

    // Random writes with random strobes and then read back
    begin_test();
    for (int i = 0; i < RAM_OPS; i++) begin
      rnd        = next_random();
      idx        = int'(rnd[mem_subsys_pkg::RAM_AW-1:0]);
      ram_idx[i] = idx;
      sel        = rnd[15:12];
      if (sel == 4'h0) begin
        sel = 4'b0001;
      end
      addr = mem_subsys_pkg::RAM_BASE | (32'(idx) << 2);
      rnd  = next_random();
      wb_access(1'b1, sel, addr, rnd, rdata, lat);
      model_write(idx, sel, rnd);
      ram_lats.push_back(lat);
    end
    for (int i = 0; i < RAM_OPS; i++) begin
      idx  = ram_idx[i];
      addr = mem_subsys_pkg::RAM_BASE | (32'(idx) << 2);
      wb_access(1'b0, 4'hF, addr, 32'h0, rdata, lat);
      ram_lats.push_back(lat);
      mask = byte_mask(model_known[idx]);
      if ((rdata & mask) !== (model_mem[idx] & mask)) begin
        report_mismatch("ram_random", model_mem[idx] & mask, rdata & mask);
      end
    end
    end_test("ram_random");

    begin_test();
    foreach (ram_lats[k]) begin
      if (ram_lats[k] != RAM_LAT) report_mismatch("ram_latency", RAM_LAT, ram_lats[k]);
    end
    end_test("ram_latency");

    // Timer pairs with the low word first
    begin_test();
    first_pair = 64'h0;
    for (int p = 0; p < 2; p++) begin
      wb_access(1'b0, 4'hF, mem_subsys_pkg::TIMER_LO_ADDR, 32'h0, rdata, lat);
      // Counter was sampled on the acknowledge edge, two edges back
      tmr_exp    = run_cycles - 64'h2;
      pair[31:0] = rdata;
      if (lat != IO_LAT) report_mismatch("timer_latency", IO_LAT, lat);
      wb_access(1'b0, 4'hF, mem_subsys_pkg::TIMER_HI_ADDR, 32'h0, rdata, lat);
      pair[63:32] = rdata;
      if (pair !== tmr_exp) report_mismatch("timer_pair", tmr_exp, pair);
      if (p == 1 && pair <= first_pair) begin
        report_failure("Timer: the second 64-bit value did not increase");
      end
      first_pair = pair;
    end
    wb_access(1'b1, 4'hF, mem_subsys_pkg::TIMER_LO_ADDR, next_random(), rdata, lat);
    wb_access(1'b0, 4'hF, mem_subsys_pkg::TIMER_LO_ADDR, 32'h0, rdata, lat);
    tmr_exp = run_cycles - 64'h2;
    if (rdata !== tmr_exp[31:0]) report_mismatch("timer_write", tmr_exp[31:0], rdata);
    end_test("timer");

    // Unmapped reads
    begin_test();
    for (int i = 0; i < UNMAP_OPS; i++) begin
      addr = next_random() & 32'hFFFF_FFFC;
      if (is_mapped(addr)) begin
        addr = addr ^ 32'h8000_0000;
      end
      wb_access(1'b0, 4'hF, addr, 32'h0, rdata, lat);
      if (rdata !== 32'h0) report_mismatch("unmapped_data", 0, rdata);
      if (lat != IO_LAT) report_mismatch("unmapped_latency", IO_LAT, lat);
    end
    end_test("unmapped");

    // Serial program load with a bus read held off by the loader
    begin_test();
    for (int w = 0; w < LOAD_WORDS; w++) begin
      load_data[w] = next_random();
    end
    send_byte(mem_subsys_pkg::PROG_START);
    if (prog_mode_o !== 1'b1) report_mismatch("load_mode", 1, prog_mode_o);
    if (sys_rst_n_o !== 1'b0) report_mismatch("load_sys_rst_n", 0, sys_rst_n_o);
    fork
      begin
        send_byte(8'(LOAD_WORDS));
        send_byte(8'h00);
        for (int w = 0; w < LOAD_WORDS; w++) begin
          for (int b = 0; b < 4; b++) begin
            send_byte(load_data[w][8*b +: 8]);
          end
        end
      end
      begin
        wb_access(1'b0, 4'hF, mem_subsys_pkg::RAM_BASE, 32'h0, held_rdata, held_lat);
        if (sys_rst_n_o !== 1'b1) begin
          report_failure("Load: a bus read was acknowledged while the system reset was held");
        end
        if (held_lat <= RAM_LAT) begin
          report_failure("Load: the bus read issued during the load was not held off");
        end
      end
    join
    if (held_rdata !== load_data[0]) report_mismatch("load_held_read", load_data[0], held_rdata);
    for (int w = 0; w < LOAD_WORDS; w++) begin
      model_write(w, 4'hF, load_data[w]);
    end
    for (int w = 0; w < LOAD_WORDS; w++) begin
      addr = mem_subsys_pkg::RAM_BASE | (32'(w) << 2);
      wb_access(1'b0, 4'hF, addr, 32'h0, rdata, lat);
      if (rdata !== model_mem[w]) report_mismatch("load_readback", model_mem[w], rdata);
    end
    // Bytes without a start marker are ignored
    for (int i = 0; i < NOISE_BYTES; i++) begin
      rnd   = next_random();
      noise = rnd[7:0];
      if (noise == mem_subsys_pkg::PROG_START) begin
        noise = noise ^ 8'h01;
      end
      send_byte(noise);
      if (prog_mode_o !== 1'b0) report_mismatch("noise_mode", 0, prog_mode_o);
      if (sys_rst_n_o !== 1'b1) report_mismatch("noise_sys_rst_n", 1, sys_rst_n_o);
    end
    end_test("program_load");

    $display("Summary: %0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/mem_subsys_pkg.sv
verilog/bus_decode.sv
verilog/ram_latency.sv
verilog/main_ram.sv
verilog/timer_regs.sv
verilog/prog_loader.sv
verilog/mem_subsys_top.sv
dv/mem_subsys_chk.sv
dv/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mem_subsys
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
